/* flist.f */
spi_pkg.sv
spi_peripheral.sv
spi_subperipheral_selector.sv
spi_register_fifo.sv
top.sv
tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_top \
    --Mdir obj_dir -o tb_top_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build returned status $status, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_top_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation binary returned status $status"
    exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* spi_peripheral.sv */
/*
 * SPI mode 0 peripheral, oversampled on the system clock.
 * Synchronizes the pins, shifts bytes in on rising SPI clock and out on
 * falling SPI clock, and turns byte boundaries into request strobes.
 */

`timescale 1ns/10ps

module spi_peripheral import spi_pkg::*; (
    input  logic                    clock_18MHz_oscillator,
    input  logic                    rst_n,

    input  logic                    spi_select_in,
    input  logic                    spi_clock_in,
    input  logic                    spi_data_in,
    output logic                    spi_data_out,

    output logic                    transaction_active,
    output subperipheral_request_t  request,
    input  subperipheral_response_t response
);

    // Two-flop synchronizers with bit 1 as the safe copy
    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_prev;

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (!rst_n) begin
            select_sync <= 2'b11;  // Deselected
            clock_sync  <= 2'b00;
            data_sync   <= 2'b00;
            clock_prev  <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select_in};
            clock_sync  <= {clock_sync[0], spi_clock_in};
            data_sync   <= {data_sync[0], spi_data_in};
            clock_prev  <= clock_sync[1];
        end
    end

    logic rising_edge;
    logic falling_edge;

    assign rising_edge        = clock_sync[1] & ~clock_prev;
    assign falling_edge       = ~clock_sync[1] & clock_prev;
    assign transaction_active = ~select_sync[1];

    peripheral_state_t state;
    logic [2:0]        bit_count;
    spi_byte_t         rx_shift;
    spi_byte_t         rx_byte;
    spi_byte_t         tx_shift;
    spi_byte_t         address_reg;
    spi_byte_t         copi_reg;
    logic              address_valid_reg;
    logic              copi_valid_reg;
    logic              cipo_request_reg;
    logic              byte_done;
    logic              shift_out;

    assign rx_byte   = {rx_shift[6:0], data_sync[1]};  // Byte including the bit sampled now
    assign byte_done = rising_edge && (bit_count == 3'd7);

    // Hold the MSB through the falling edge right after a byte boundary
    assign shift_out = falling_edge && (state == DATA) && (bit_count != 3'd0);

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (!rst_n) begin
            state             <= IDLE;
            bit_count         <= 3'd0;
            address_valid_reg <= 1'b0;
            copi_valid_reg    <= 1'b0;
            cipo_request_reg  <= 1'b0;
            spi_data_out      <= 1'b0;
        end else begin
            address_valid_reg <= 1'b0;
            copi_valid_reg    <= 1'b0;
            cipo_request_reg  <= 1'b0;

            case (state)
                IDLE: begin
                    bit_count    <= 3'd0;
                    spi_data_out <= 1'b0;
                    if (transaction_active) state <= ADDRESS;
                end

                ADDRESS, DATA: begin
                    if (!transaction_active) begin
                        state <= IDLE;  // Partial byte is dropped
                    end else begin
                        if (rising_edge) bit_count <= bit_count + 3'd1;

                        if (byte_done) begin
                            cipo_request_reg <= 1'b1;
                            if (state == ADDRESS) begin
                                address_valid_reg <= 1'b1;
                                state             <= DATA;
                            end else begin
                                copi_valid_reg <= 1'b1;
                            end
                        end

                        if (response.cipo_valid) spi_data_out <= response.cipo[7];
                        else if (shift_out) spi_data_out <= tx_shift[7];
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // Shift registers and received bytes
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (rising_edge) rx_shift <= rx_byte;

        if (byte_done && state == ADDRESS) address_reg <= rx_byte;
        if (byte_done && state == DATA) copi_reg <= rx_byte;

        if (response.cipo_valid) begin
            tx_shift <= {response.cipo[6:0], 1'b0};  // MSB already on the pin
        end else if (shift_out) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign request = '{
        address:       address_reg,
        address_valid: address_valid_reg,
        copi:          copi_reg,
        copi_valid:    copi_valid_reg,
        cipo_request:  cipo_request_reg
    };

endmodule

/* spi_pkg.sv */
/*
 * Shared types and constants for the SPI register block.
 * Byte and level widths, register map, chip ID, the request and
 * response bundles between peripheral and selector, and the FSM states.
 */

package spi_pkg;

    typedef logic [7:0] spi_byte_t;    // Any byte on the SPI wires
    typedef logic [7:0] fifo_level_t;  // FIFO fill count seen by the host

    // Register map
    localparam spi_byte_t ADDR_CHIP_ID    = 8'hDB;
    localparam spi_byte_t ADDR_FIFO_WRITE = 8'h20;
    localparam spi_byte_t ADDR_FIFO_READ  = 8'h21;
    localparam spi_byte_t ADDR_FIFO_LEVEL = 8'h22;

    localparam spi_byte_t CHIP_ID            = 8'h81;
    localparam spi_byte_t UNKNOWN_READ_VALUE = 8'hFF;  // Unmapped or write-only address
    localparam spi_byte_t EMPTY_READ_VALUE   = 8'h00;  // Pop from an empty FIFO

    // Peripheral to selector with single-cycle valid pulses
    typedef struct packed {
        spi_byte_t address;
        logic      address_valid;
        spi_byte_t copi;
        logic      copi_valid;
        logic      cipo_request;  // Next read byte wanted
    } subperipheral_request_t;

    // Selector back to peripheral one cycle after cipo_request
    typedef struct packed {
        spi_byte_t cipo;
        logic      cipo_valid;
    } subperipheral_response_t;

    typedef enum logic [1:0] {
        IDLE,
        ADDRESS,
        DATA
    } peripheral_state_t;

endpackage

/* spi_register_fifo.sv */
/*
 * Circular byte FIFO behind the SPI FIFO registers.
 * A push when full is dropped. Every pop request returns a byte one
 * cycle later, the head byte or EMPTY_READ_VALUE when empty.
 */

`timescale 1ns/10ps

module spi_register_fifo import spi_pkg::*; #(
    parameter int FIFO_DEPTH = 16  // Power of two from 2 to 128
) (
    input  logic        clock_18MHz_oscillator,
    input  logic        rst_n,

    input  logic        push,
    input  spi_byte_t   write_data,

    input  logic        pop_request,
    output spi_byte_t   read_data,
    output logic        read_valid,

    output fifo_level_t level
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    spi_byte_t            memory [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] write_ptr;
    logic [PTR_WIDTH-1:0] read_ptr;
    logic [PTR_WIDTH:0]   count;  // One extra bit to hold FIFO_DEPTH
    logic                 full;
    logic                 empty;
    logic                 do_push;
    logic                 do_pop;

    assign full    = (count == FIFO_DEPTH[PTR_WIDTH:0]);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop_request && !empty;

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (!rst_n) begin
            write_ptr  <= '0;
            read_ptr   <= '0;
            count      <= '0;
            read_valid <= 1'b0;
        end else begin
            read_valid <= pop_request;

            if (do_push) write_ptr <= write_ptr + 1'b1;  // Wraps at the power of two
            if (do_pop) read_ptr <= read_ptr + 1'b1;

            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read byte
    always_ff @(posedge clock_18MHz_oscillator) begin
        if (do_push) memory[write_ptr] <= write_data;

        if (pop_request) begin
            read_data <= empty ? EMPTY_READ_VALUE : memory[read_ptr];
        end
    end

    assign level = fifo_level_t'(count);

endmodule

/* spi_subperipheral_selector.sv */
/*
 * Routes each SPI transaction by its register address.
 * FIFO addresses go to the byte FIFO; chip ID, level and unmapped
 * reads are answered here, all one cycle after cipo_request.
 */

`timescale 1ns/10ps

module spi_subperipheral_selector import spi_pkg::*; (
    input  logic                    clock_18MHz_oscillator,
    input  logic                    rst_n,

    input  subperipheral_request_t  request,
    input  logic                    transaction_active,
    output subperipheral_response_t response,

    output logic                    fifo_push,
    output spi_byte_t               fifo_write_data,
    output logic                    fifo_pop_request,
    input  spi_byte_t               fifo_read_data,
    input  logic                    fifo_read_valid,
    input  fifo_level_t             fifo_level
);

    spi_byte_t held_address;
    logic      address_held;
    spi_byte_t current_address;
    logic      address_known;
    spi_byte_t local_cipo;
    logic      local_cipo_valid;

    // First cipo_request comes with address_valid, so bypass the latch then
    assign current_address = request.address_valid ? request.address : held_address;
    assign address_known   = request.address_valid | address_held;

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (!rst_n) begin
            address_held     <= 1'b0;
            local_cipo_valid <= 1'b0;
        end else begin
            if (!transaction_active) address_held <= 1'b0;
            else if (request.address_valid) address_held <= 1'b1;

            local_cipo_valid <= request.cipo_request && (current_address != ADDR_FIFO_READ);
        end
    end

    always_ff @(posedge clock_18MHz_oscillator) begin
        if (request.address_valid) held_address <= request.address;

        if (request.cipo_request) begin
            case (current_address)
                ADDR_CHIP_ID:    local_cipo <= CHIP_ID;
                ADDR_FIFO_LEVEL: local_cipo <= fifo_level;
                default:         local_cipo <= UNKNOWN_READ_VALUE;  // Write-only too
            endcase
        end
    end

    assign fifo_push        = request.copi_valid && address_known &&
                              (current_address == ADDR_FIFO_WRITE);
    assign fifo_write_data  = request.copi;
    assign fifo_pop_request = request.cipo_request && address_known &&
                              (current_address == ADDR_FIFO_READ);

    assign response = '{
        cipo:       fifo_read_valid ? fifo_read_data : local_cipo,
        cipo_valid: fifo_read_valid | local_cipo_valid
    };

endmodule

/* tb_top.sv */
/*
 * Directed testbench for the SPI register block.
 * An SPI mode 0 host drives the pins of top and checks chip ID,
 * FIFO order, overflow, empty and unmapped reads, and an aborted write.
 */

`timescale 1ns/10ps

module tb_top import spi_pkg::*; ();

    localparam int HALF_PERIOD    = 8;      // System clocks per SPI half period
    localparam int TIMEOUT_CYCLES = 60000;
    localparam int FIFO_DEPTH     = 16;

    logic clock_18MHz_oscillator;
    logic rst_n;
    logic spi_select_in;
    logic spi_clock_in;
    logic spi_data_in;
    logic spi_data_out;

    spi_byte_t tx_bytes [32];  // Data bytes sent after the address
    spi_byte_t rx_bytes [32];  // Bytes shifted in from cipo
    int        cycle_count = 0;
    int        error_count = 0;
    int        pass_count  = 0;
    int        fail_count  = 0;

    top #(.FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .spi_select_in(spi_select_in),
        .spi_clock_in(spi_clock_in),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out)
    );

    initial begin
        clock_18MHz_oscillator = 1'b0;
        forever #10 clock_18MHz_oscillator = ~clock_18MHz_oscillator;
    end

    always @(posedge clock_18MHz_oscillator) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clock_18MHz_oscillator);
    endtask

    // One mode 0 bit with cipo sampled at the rising SPI clock
    task automatic transfer_bit(input logic value, output logic received);
        spi_data_in <= value;
        wait_clocks(HALF_PERIOD);
        spi_clock_in <= 1'b1;
        received = spi_data_out;
        wait_clocks(HALF_PERIOD);
        spi_clock_in <= 1'b0;
    endtask

    task automatic transfer_byte(input spi_byte_t value, output spi_byte_t received);
        for (int i = 7; i >= 0; i--) transfer_bit(value[i], received[i]);
    endtask

    // Address byte, then byte_count data bytes, then abort_bits extra bits of tx_bytes[0]
    task automatic spi_transfer(input spi_byte_t address, input int byte_count,
                                input int abort_bits);
        spi_byte_t ignored;
        logic      bit_in;
        @(posedge clock_18MHz_oscillator);
        spi_select_in <= 1'b0;
        wait_clocks(HALF_PERIOD);
        transfer_byte(address, ignored);
        for (int i = 0; i < byte_count; i++) transfer_byte(tx_bytes[i], rx_bytes[i]);
        for (int i = 0; i < abort_bits; i++) transfer_bit(tx_bytes[0][7 - i], bit_in);
        wait_clocks(HALF_PERIOD);
        spi_select_in <= 1'b1;
        wait_clocks(2 * HALF_PERIOD);  // Idle gap between transactions
    endtask

    task automatic compare_byte(input string name, input spi_byte_t expected,
                                input spi_byte_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected 0x%02h, got 0x%02h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_level(input fifo_level_t expected);
        spi_transfer(ADDR_FIFO_LEVEL, 1, 0);
        compare_byte("fifo_level", expected, rx_bytes[0]);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_chip_id();
        int errors_before = error_count;
        spi_transfer(ADDR_CHIP_ID, 1, 0);
        compare_byte("chip_id", CHIP_ID, rx_bytes[0]);
        spi_transfer(ADDR_CHIP_ID, 3, 0);
        for (int i = 0; i < 3; i++) compare_byte("chip_id", CHIP_ID, rx_bytes[i]);
        report_test("chip_id", errors_before);
    endtask

    // Writes count random bytes, then reads back min(count, depth) in order
    task automatic test_fifo_fill(input string name, input int count);
        int        errors_before = error_count;
        int        stored;
        spi_byte_t written [32];
        stored = (count > FIFO_DEPTH) ? FIFO_DEPTH : count;
        for (int i = 0; i < count; i++) begin
            tx_bytes[i] = spi_byte_t'($urandom);
            written[i]  = tx_bytes[i];
        end
        spi_transfer(ADDR_FIFO_WRITE, count, 0);
        check_level(fifo_level_t'(stored));
        spi_transfer(ADDR_FIFO_READ, stored, 0);
        for (int i = 0; i < stored; i++) compare_byte("fifo_read", written[i], rx_bytes[i]);
        check_level(8'd0);  // Drained
        report_test(name, errors_before);
    endtask

    task automatic test_empty_unknown();
        int errors_before = error_count;
        spi_transfer(ADDR_FIFO_READ, 2, 0);
        compare_byte("empty_read", EMPTY_READ_VALUE, rx_bytes[0]);
        compare_byte("empty_read", EMPTY_READ_VALUE, rx_bytes[1]);
        spi_transfer(8'h55, 1, 0);
        compare_byte("unknown_read", UNKNOWN_READ_VALUE, rx_bytes[0]);
        report_test("empty_unknown", errors_before);
    endtask

    task automatic test_abort();
        int        errors_before = error_count;
        spi_byte_t value;
        tx_bytes[0] = spi_byte_t'($urandom);
        spi_transfer(ADDR_FIFO_WRITE, 0, 4);  // Select rises mid byte
        check_level(8'd0);
        value       = spi_byte_t'($urandom);
        tx_bytes[0] = value;
        spi_transfer(ADDR_FIFO_WRITE, 1, 0);
        spi_transfer(ADDR_FIFO_READ, 1, 0);
        compare_byte("fifo_read", value, rx_bytes[0]);
        report_test("abort", errors_before);
    endtask

    initial begin
        void'($urandom(32'h3053e1d1));
        for (int i = 0; i < 32; i++) tx_bytes[i] = 8'h00;
        rst_n         <= 1'b0;
        spi_select_in <= 1'b1;
        spi_clock_in  <= 1'b0;
        spi_data_in   <= 1'b0;
        wait_clocks(2);
        rst_n <= 1'b1;
        wait_clocks(4);

        test_chip_id();
        test_fifo_fill("fifo_order", 10);
        test_fifo_fill("overflow", 20);
        test_empty_unknown();
        test_abort();

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* top.sv */
/*
 * SPI register block top level.
 * Peripheral, address selector and byte FIFO on one clock;
 * FIFO_DEPTH is set here and passed down to the FIFO.
 */

`timescale 1ns/10ps

module top import spi_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic clock_18MHz_oscillator,
    input  logic rst_n,

    input  logic spi_select_in,
    input  logic spi_clock_in,
    input  logic spi_data_in,
    output logic spi_data_out
);

    subperipheral_request_t  request;
    subperipheral_response_t response;
    logic                    transaction_active;

    logic        fifo_push;
    spi_byte_t   fifo_write_data;
    logic        fifo_pop_request;
    spi_byte_t   fifo_read_data;
    logic        fifo_read_valid;
    fifo_level_t fifo_level;

    spi_peripheral spi_peripheral (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .spi_select_in(spi_select_in),
        .spi_clock_in(spi_clock_in),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .transaction_active(transaction_active),
        .request(request),
        .response(response)
    );

    spi_subperipheral_selector spi_subperipheral_selector (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .request(request),
        .transaction_active(transaction_active),
        .response(response),
        .fifo_push(fifo_push),
        .fifo_write_data(fifo_write_data),
        .fifo_pop_request(fifo_pop_request),
        .fifo_read_data(fifo_read_data),
        .fifo_read_valid(fifo_read_valid),
        .fifo_level(fifo_level)
    );

    spi_register_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) spi_register_fifo (
        .clock_18MHz_oscillator(clock_18MHz_oscillator),
        .rst_n(rst_n),
        .push(fifo_push),
        .write_data(fifo_write_data),
        .pop_request(fifo_pop_request),
        .read_data(fifo_read_data),
        .read_valid(fifo_read_valid),
        .level(fifo_level)
    );

endmodule
